//--- Makefile
# Verilator simulation of the bus cycle unit
# Any variable can be overridden, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= bus_unit_tb
FILELIST  ?= cft_bus.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

# Exit status of the simulation binary is the test result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- cft_bus.f
+incdir+design
design/cft_bus_pkg.sv
design/cycle_sequencer.sv
design/phase_timer.sv
design/databus.sv
design/wait_state_device.sv
design/bus_unit_top.sv
tests/bus_unit_checker.sv
tests/bus_unit_tb.sv

//--- design/bus_unit_top.sv
////////////////////////////////////////
// Bus cycle unit with its external device attached
// Cycle length is 4 clk3 plus the space's wait count
////////////////////////////////////////

`timescale 1ns/1ps
`include "cft_bus_config.svh"

module bus_unit_top (
   input  logic                    clk3,
   input  logic                    arst_n,
   input  logic                    nhalt,
   input  logic                    req_strobe,
   input  cft_bus_pkg::bus_req_t   req,
   output logic                    busy,
   output logic                    rd_done,
   output logic [`CFT_DATA_W-1:0]  rdata,
   output logic                    wr_done
);

   cft_bus_pkg::bus_ctl_t   ctl;
   cft_bus_pkg::phase_e     phase;
   logic [`CFT_DATA_W-1:0]  wdata;
   logic [`CFT_DATA_W-1:0]  db_out;
   logic [`CFT_DATA_W-1:0]  db_in;
   logic                    cycle_active;
   logic                    cycle_end;
   logic                    t34;
   logic                    wstb;
   logic                    nw;
   logic                    busen;
   logic                    nwaiting;
   logic                    nws;

   cycle_sequencer u_seq (
      .clk3, .arst_n, .nhalt, .req_strobe, .req, .phase, .cycle_end, .nwaiting,
      .ctl, .wdata, .cycle_active, .busy, .rd_done, .wr_done
   );

   phase_timer u_timer (
      .clk3, .arst_n, .cycle_active, .nwaiting, .phase, .t34, .wstb, .cycle_end
   );

   databus u_bus (
      .clk3, .arst_n, .nhalt, .t34, .wstb, .ctl, .nws, .wdata, .db_in,
      .nw, .busen, .nwaiting, .db_out, .rdata
   );

   wait_state_device u_dev (
      .clk3, .arst_n, .ctl, .nw, .busen, .db_out, .nws, .db_in
   );

endmodule

//--- design/cft_bus_config.svh
////////////////////////////////////////
// Bus unit sizes and wait counts. Depths must be powers of two
// because only the low address bits pick a word
////////////////////////////////////////

`ifndef CFT_BUS_CONFIG_SVH
`define CFT_BUS_CONFIG_SVH

// Bus widths
`define CFT_DATA_W    16
`define CFT_ADDR_W    16

// External device spaces
`define CFT_MEM_DEPTH 256   // Low 8 address bits
`define CFT_IO_DEPTH  16    // Low 4 address bits

// Wait states owed per cycle, by space
`define CFT_MEM_WAIT  1
`define CFT_IO_WAIT   3

`endif

//--- design/cft_bus_pkg.sv
////////////////////////////////////////
// Shared types of the bus cycle unit
// Select and strobe fields are active low
////////////////////////////////////////

`include "cft_bus_config.svh"

package cft_bus_pkg;

   // Kind of bus cycle the microcode asks for
   typedef enum logic [2:0] {
      KIND_NONE   = 3'd0,
      KIND_MEM_RD = 3'd1,
      KIND_MEM_WR = 3'd2,
      KIND_IO_RD  = 3'd3,
      KIND_IO_WR  = 3'd4
   } cycle_kind_e;

   // Four clk3 phases per bus cycle
   typedef enum logic [1:0] {
      PH_T1 = 2'd0,
      PH_T2 = 2'd1,   // Stretched by wait states
      PH_T3 = 2'd2,   // Write strobe window
      PH_T4 = 2'd3    // Read data sampled at its end
   } phase_e;

   // Sequencer FSM
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_CYCLE = 2'd1,
      ST_DONE  = 2'd2
   } seq_state_e;

   // Request from the microcode side, 35 bits
   typedef struct packed {
      cycle_kind_e             kind;
      logic [`CFT_ADDR_W-1:0]  addr;
      logic [`CFT_DATA_W-1:0]  wdata;
   } bus_req_t;

   // Address and control bundle on the external bus
   typedef struct packed {
      logic                    nmem;   // Memory space select
      logic                    nio;    // I/O space select
      logic                    nr;     // Read flag, also buffer direction
      logic                    nwen;   // Write enable into the nw driver
      logic [`CFT_ADDR_W-1:0]  addr;
   } bus_ctl_t;

endpackage

//--- design/cycle_sequencer.sv
////////////////////////////////////////
// Takes one request strobe at a time. Strobes while busy,
// halted, or of KIND_NONE are dropped without notice
////////////////////////////////////////

`timescale 1ns/1ps
`include "cft_bus_config.svh"

module cycle_sequencer (
   input  logic                    clk3,
   input  logic                    arst_n,
   input  logic                    nhalt,
   input  logic                    req_strobe,
   input  cft_bus_pkg::bus_req_t   req,
   input  cft_bus_pkg::phase_e     phase,
   input  logic                    cycle_end,     // T4 of the running cycle
   input  logic                    nwaiting,
   output cft_bus_pkg::bus_ctl_t   ctl,
   output logic [`CFT_DATA_W-1:0]  wdata,
   output logic                    cycle_active,
   output logic                    busy,
   output logic                    rd_done,
   output logic                    wr_done
);

   cft_bus_pkg::seq_state_e  state;
   cft_bus_pkg::cycle_kind_e kind_q;
   logic                     nmem_q;
   logic                     nio_q;
   logic                     nr_q;
   logic                     nwen;
   logic [`CFT_ADDR_W-1:0]   addr_q;
   logic                     accept;
   logic                     is_read;
   logic                     is_write;

   // Acceptance gate
   assign accept = req_strobe && nhalt && (state == cft_bus_pkg::ST_IDLE) &&
                   (req.kind != cft_bus_pkg::KIND_NONE);

   assign is_read  = kind_q inside {cft_bus_pkg::KIND_MEM_RD, cft_bus_pkg::KIND_IO_RD};
   assign is_write = kind_q inside {cft_bus_pkg::KIND_MEM_WR, cft_bus_pkg::KIND_IO_WR};

   ////////////////////////////////////////
   // FSM and decoded selects
   ////////////////////////////////////////
   always_ff @(posedge clk3 or negedge arst_n) begin
      if (!arst_n) begin
         state  <= cft_bus_pkg::ST_IDLE;
         kind_q <= cft_bus_pkg::KIND_NONE;
         nmem_q <= 1'b1;
         nio_q  <= 1'b1;
         nr_q   <= 1'b1;
      end else begin
         case (state)
            cft_bus_pkg::ST_IDLE: if (accept) begin
               state  <= cft_bus_pkg::ST_CYCLE;
               kind_q <= req.kind;
               nmem_q <= !(req.kind inside {cft_bus_pkg::KIND_MEM_RD, cft_bus_pkg::KIND_MEM_WR});
               nio_q  <= !(req.kind inside {cft_bus_pkg::KIND_IO_RD, cft_bus_pkg::KIND_IO_WR});
               nr_q   <= !(req.kind inside {cft_bus_pkg::KIND_MEM_RD, cft_bus_pkg::KIND_IO_RD});
            end
            cft_bus_pkg::ST_CYCLE: if (cycle_end) begin
               state  <= cft_bus_pkg::ST_DONE;   // Release the bus after T4
               nmem_q <= 1'b1;
               nio_q  <= 1'b1;
               nr_q   <= 1'b1;
            end
            default: state <= cft_bus_pkg::ST_IDLE;   // ST_DONE lasts one cycle
         endcase
      end
   end

   // Address and write data, loaded on accept only
   always_ff @(posedge clk3) begin
      if (accept) begin
         addr_q <= req.addr;
         wdata  <= req.wdata;
      end
   end

   // Write enable only in T3 once the device stops waiting
   assign nwen = !(is_write && (state == cft_bus_pkg::ST_CYCLE) &&
                   (phase == cft_bus_pkg::PH_T3) && nwaiting);

   assign ctl = '{nmem: nmem_q, nio: nio_q, nr: nr_q, nwen: nwen, addr: addr_q};

   assign cycle_active = (state == cft_bus_pkg::ST_CYCLE);
   assign busy         = (state != cft_bus_pkg::ST_IDLE);   // Drops after the done cycle
   assign rd_done      = (state == cft_bus_pkg::ST_DONE) && is_read;
   assign wr_done      = (state == cft_bus_pkg::ST_DONE) && is_write;

endmodule

//--- design/databus.sv
////////////////////////////////////////
// Bus glue with split read and write data paths
// nw is held high, not floated, while halted
////////////////////////////////////////

`timescale 1ns/1ps
`include "cft_bus_config.svh"

module databus (
   input  logic                    clk3,
   input  logic                    arst_n,
   input  logic                    nhalt,
   input  logic                    t34,
   input  logic                    wstb,
   input  cft_bus_pkg::bus_ctl_t   ctl,
   input  logic                    nws,        // From the device, low to wait
   input  logic [`CFT_DATA_W-1:0]  wdata,
   input  logic [`CFT_DATA_W-1:0]  db_in,
   output logic                    nw,
   output logic                    busen,
   output logic                    nwaiting,
   output logic [`CFT_DATA_W-1:0]  db_out,
   output logic [`CFT_DATA_W-1:0]  rdata
);

   logic nws_in_t34;   // Wait request seen in T1/T2 only
   logic t3;
   logic rd_sel;

   ////////////////////////////////////////
   // Wait state flip-flop
   ////////////////////////////////////////

   // Requests in T3/T4 are too late and ignored
   assign nws_in_t34 = nws | t34;

   always_ff @(posedge clk3 or negedge arst_n) begin
      if (!arst_n)
         nwaiting <= 1'b1;
      else
         nwaiting <= nws_in_t34;   // Set low, clears once nws goes high
   end

   ////////////////////////////////////////
   // nw driver and buffer gating
   ////////////////////////////////////////
   assign t3 = t34 && !wstb;

   // Low only in T3 of a write, not waiting, not halted
   assign nw = !(nhalt && nwaiting && !ctl.nwen && t3);

   // Buffers open on any select once waits are over
   assign busen  = nwaiting && !(ctl.nmem && ctl.nio);
   assign rd_sel = busen && !ctl.nr;

   // Write path, nr high means CPU drives the bus
   assign db_out = (busen && ctl.nr) ? wdata : '0;

   // Read data captured at the edge that ends T4
   always_ff @(posedge clk3) begin
      if (wstb && rd_sel)
         rdata <= db_in;
   end

endmodule

//--- design/phase_timer.sv
////////////////////////////////////////
// T1..T4 counter, parked in T1 between cycles
// T2 repeats for as long as nwaiting is low
////////////////////////////////////////

`timescale 1ns/1ps

module phase_timer (
   input  logic                 clk3,
   input  logic                 arst_n,
   input  logic                 cycle_active,
   input  logic                 nwaiting,
   output cft_bus_pkg::phase_e  phase,
   output logic                 t34,
   output logic                 wstb,
   output logic                 cycle_end
);

   cft_bus_pkg::phase_e phase_nx;

   // Next phase
   always_comb begin
      phase_nx = phase;
      case (phase)
         cft_bus_pkg::PH_T1: if (cycle_active) phase_nx = cft_bus_pkg::PH_T2;
         cft_bus_pkg::PH_T2: if (nwaiting) phase_nx = cft_bus_pkg::PH_T3;   // Hold on wait
         cft_bus_pkg::PH_T3: phase_nx = cft_bus_pkg::PH_T4;
         default:            phase_nx = cft_bus_pkg::PH_T1;   // T4 wraps
      endcase
   end

   always_ff @(posedge clk3 or negedge arst_n) begin
      if (!arst_n)
         phase <= cft_bus_pkg::PH_T1;
      else
         phase <= phase_nx;
   end

   // Second half of the cycle
   assign t34  = (phase == cft_bus_pkg::PH_T3) || (phase == cft_bus_pkg::PH_T4);
   assign wstb = (phase == cft_bus_pkg::PH_T4);        // High in T4 only
   assign cycle_end = wstb && cycle_active;            // Tells the sequencer to finish

endmodule

//--- design/wait_state_device.sv
////////////////////////////////////////
// Bus-side memory and I/O model with fixed wait counts
// Upper address bits are ignored, so spaces alias
////////////////////////////////////////

`timescale 1ns/1ps
`include "cft_bus_config.svh"

module wait_state_device (
   input  logic                    clk3,
   input  logic                    arst_n,
   input  cft_bus_pkg::bus_ctl_t   ctl,
   input  logic                    nw,
   input  logic                    busen,
   input  logic [`CFT_DATA_W-1:0]  db_out,
   output logic                    nws,
   output logic [`CFT_DATA_W-1:0]  db_in
);

   localparam int MEM_AW   = $clog2(`CFT_MEM_DEPTH);
   localparam int IO_AW    = $clog2(`CFT_IO_DEPTH);
   localparam int MAX_WAIT = (`CFT_IO_WAIT > `CFT_MEM_WAIT) ? `CFT_IO_WAIT : `CFT_MEM_WAIT;
   localparam int CNT_W    = $clog2(MAX_WAIT + 1) > 0 ? $clog2(MAX_WAIT + 1) : 1;

   logic [`CFT_DATA_W-1:0] mem    [`CFT_MEM_DEPTH];
   logic [`CFT_DATA_W-1:0] io_reg [`CFT_IO_DEPTH];
   logic [CNT_W-1:0]       cnt;       // Waits still owed after this cycle
   logic [CNT_W-1:0]       cnt_eff;   // Waits owed in this cycle
   logic                   sel;
   logic                   sel_q;
   logic                   new_sel;
   logic [MEM_AW-1:0]      mem_idx;
   logic [IO_AW-1:0]       io_idx;

   assign mem_idx = ctl.addr[MEM_AW-1:0];
   assign io_idx  = ctl.addr[IO_AW-1:0];

   ////////////////////////////////////////
   // Wait counter
   ////////////////////////////////////////
   assign sel     = !ctl.nmem || !ctl.nio;
   assign new_sel = sel && !sel_q;   // First cycle of a select, i.e. T1

   // Load the space's count as the select appears
   assign cnt_eff = !new_sel   ? cnt :
                    !ctl.nmem  ? CNT_W'(`CFT_MEM_WAIT) : CNT_W'(`CFT_IO_WAIT);

   assign nws = (cnt_eff == '0);   // Low while waits are owed

   always_ff @(posedge clk3 or negedge arst_n) begin
      if (!arst_n) begin
         sel_q <= 1'b0;
         cnt   <= '0;
      end else begin
         sel_q <= sel;
         cnt   <= (cnt_eff != '0) ? cnt_eff - 1'b1 : '0;
      end
   end

   ////////////////////////////////////////
   // Storage
   ////////////////////////////////////////
   always_ff @(posedge clk3 or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `CFT_MEM_DEPTH; i++)
            mem[i] <= '0;
         for (int j = 0; j < `CFT_IO_DEPTH; j++)
            io_reg[j] <= '0;
      end else if (!nw) begin   // Edge that ends T3
         if (!ctl.nmem)
            mem[mem_idx] <= db_out;
         if (!ctl.nio)
            io_reg[io_idx] <= db_out;
      end
   end

   // Read path, driven only while the buffers face the CPU
   assign db_in = !(busen && !ctl.nr) ? '0 :
                  !ctl.nmem           ? mem[mem_idx] : io_reg[io_idx];

endmodule

//--- tests/bus_unit_checker.sv
////////////////////////////////////////
// Bound to bus_unit_top, where the timer phase
// and the databus strobes are both visible
////////////////////////////////////////

`timescale 1ns/1ps

module bus_unit_checker (
   input  logic                 clk3,
   input  logic                 arst_n,
   input  logic                 nw,
   input  logic                 nhalt,
   input  logic                 busen,
   input  logic                 nwaiting,
   input  cft_bus_pkg::phase_e  phase
);

   logic in_t3;

   assign in_t3 = (phase == cft_bus_pkg::PH_T3);   // T3 straight from the timer

   // Write strobe only inside T3
   a_nw_in_t3: assert property (@(posedge clk3) disable iff (!arst_n) !nw |-> in_t3)
      else $error("nw low outside T3");

   // Held inactive during halt
   a_nw_halt: assert property (@(posedge clk3) disable iff (!arst_n) !nhalt |-> nw)
      else $error("nw low while nhalt is low");

   a_busen_wait: assert property (@(posedge clk3) disable iff (!arst_n) !nwaiting |-> !busen)
      else $error("busen high during a wait state");

   // Hold, step by one, or wrap to T1
   a_phase_step: assert property (@(posedge clk3) disable iff (!arst_n)
      (phase == $past(phase)) || (phase == 2'($past(phase) + 2'd1)) ||
      (phase == cft_bus_pkg::PH_T1))
      else $error("phase skipped a step");

endmodule

//--- tests/bus_unit_tb.sv
////////////////////////////////////////
// Inputs change on the falling clk3 edge, outputs sampled there
// Model assumes memory and I/O registers cleared by reset
////////////////////////////////////////

`timescale 1ns/1ps
`include "cft_bus_config.svh"

module bus_unit_tb;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 8;
   localparam int ADDR_W       = `CFT_ADDR_W;
   localparam int DATA_W       = `CFT_DATA_W;
   localparam int MEM_AW       = $clog2(`CFT_MEM_DEPTH);
   localparam int IO_AW        = $clog2(`CFT_IO_DEPTH);
   localparam int N_INIT       = 8;     // Reads straight after reset
   localparam int N_MEM        = 48;
   localparam int N_IO         = 32;
   localparam int N_RECHECK    = 8;
   localparam int N_HALT       = 4;     // Two requests' time each
   localparam int N_BUSY       = 4;     // Three requests' time each
   localparam int NUM_REQ      = N_INIT + N_MEM + N_IO + N_RECHECK + 2 * N_HALT + 3 * N_BUSY;
   localparam int CYCLE_BUDGET = 4 + `CFT_IO_WAIT + 4;
   localparam int WATCHDOG_CYCLES = NUM_REQ * CYCLE_BUDGET + RESET_CYCLES;
   localparam logic [ADDR_W-1:0] MEM_ADDR_MASK = 16'hff0f;   // 16 words, aliased

   logic                    clk3;
   logic                    arst_n;
   logic                    nhalt;
   logic                    req_strobe;
   cft_bus_pkg::bus_req_t   req;
   logic                    busy;
   logic                    rd_done;
   logic                    wr_done;
   logic [DATA_W-1:0]       rdata;

   logic [DATA_W-1:0]       mem_model [`CFT_MEM_DEPTH];   // Shadow memory
   logic [DATA_W-1:0]       io_model  [`CFT_IO_DEPTH];    // Shadow I/O registers
   logic [DATA_W-1:0]       last_rdata;
   bit                      have_rdata;

   bus_unit_top u_dut (
      .clk3, .arst_n, .nhalt, .req_strobe, .req, .busy, .rd_done, .rdata, .wr_done
   );

   // Strobe, enable and phase rules on the live top-level nets
   bind bus_unit_top bus_unit_checker u_chk (
      .clk3, .arst_n, .nw, .nhalt, .busen, .nwaiting, .phase
   );

   initial begin
      clk3 = 1'b0;
      forever #(CLK_PERIOD / 2) clk3 = ~clk3;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("TB FAILED");
      $fatal(1, "Watchdog expired before all requests finished");
   end

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////
   function automatic bit is_mem(input cft_bus_pkg::cycle_kind_e kind);
      return (kind == cft_bus_pkg::KIND_MEM_RD) || (kind == cft_bus_pkg::KIND_MEM_WR);
   endfunction

   function automatic logic [DATA_W-1:0] model_read(input cft_bus_pkg::bus_req_t r);
      logic [MEM_AW-1:0] mi;
      logic [IO_AW-1:0]  ii;
      mi = MEM_AW'(r.addr % `CFT_MEM_DEPTH);
      ii = IO_AW'(r.addr % `CFT_IO_DEPTH);
      if (is_mem(r.kind))
         return mem_model[mi];
      return io_model[ii];
   endfunction

   task automatic model_write(input cft_bus_pkg::bus_req_t r);
      logic [MEM_AW-1:0] mi;
      logic [IO_AW-1:0]  ii;
      mi = MEM_AW'(r.addr % `CFT_MEM_DEPTH);
      ii = IO_AW'(r.addr % `CFT_IO_DEPTH);
      if (is_mem(r.kind))
         mem_model[mi] = r.wdata;
      else
         io_model[ii] = r.wdata;
   endtask

   function automatic cft_bus_pkg::bus_req_t random_req(input bit io_space);
      cft_bus_pkg::bus_req_t r;
      bit wr;
      wr = ($urandom_range(1) != 0);
      if (io_space) begin
         r.kind = wr ? cft_bus_pkg::KIND_IO_WR : cft_bus_pkg::KIND_IO_RD;
         r.addr = ADDR_W'($urandom);   // Upper bits must alias away
      end else begin
         r.kind = wr ? cft_bus_pkg::KIND_MEM_WR : cft_bus_pkg::KIND_MEM_RD;
         r.addr = ADDR_W'($urandom) & MEM_ADDR_MASK;
      end
      r.wdata = DATA_W'($urandom);
      return r;
   endfunction

   ////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////
   task automatic fail_run(input string why);
      $display("TB FAILED");
      $fatal(1, "%s", why);
   endtask

   task automatic check_rdata(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("MISMATCH rdata addr 0x%h: got 0x%h expected 0x%h", addr, got, exp);
         fail_run("Read data differs from the model");
      end
   endtask

   task automatic check_latency(input cft_bus_pkg::cycle_kind_e kind, input int got,
                                input int exp);
      if (got != exp) begin
         $display("MISMATCH latency %s: got 0x%h expected 0x%h", kind.name(), got, exp);
         fail_run("Cycle length differs from the model");
      end
   endtask

   task automatic check_state(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
         fail_run("Status output differs from the model");
      end
   endtask

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   // Enter and leave at a falling edge with the unit idle
   task automatic run_cycle(input cft_bus_pkg::bus_req_t r, input bit inject,
                            input cft_bus_pkg::bus_req_t extra);
      int                cycles;
      int                exp_lat;
      bit                done;
      bit                rd;
      logic [DATA_W-1:0] exp_data;
      rd       = (r.kind == cft_bus_pkg::KIND_MEM_RD) || (r.kind == cft_bus_pkg::KIND_IO_RD);
      exp_lat  = 4 + (is_mem(r.kind) ? `CFT_MEM_WAIT : `CFT_IO_WAIT);
      exp_data = model_read(r);
      req        = r;
      req_strobe = 1'b1;
      @(posedge clk3);   // Accepting edge
      cycles = 0;
      done   = 1'b0;
      while (!done) begin
         @(negedge clk3);
         done       = rd_done || wr_done;
         req_strobe = 1'b0;
         if (inject && cycles == 0) begin
            req        = extra;
            req_strobe = 1'b1;   // Lands while busy
         end
         if (!done) begin
            check_state("busy", busy, 1'b1);
            if (cycles > CYCLE_BUDGET)
               fail_run("No done pulse after an accepted request");
            @(posedge clk3);
            cycles++;
         end
      end
      check_state("rd_done", rd_done, rd);
      check_state("wr_done", wr_done, !rd);
      check_latency(r.kind, cycles, exp_lat);
      if (rd) begin
         check_rdata(r.addr, rdata, exp_data);
         last_rdata = rdata;
         have_rdata = 1'b1;
      end else begin
         if (have_rdata)
            check_rdata(r.addr, rdata, last_rdata);   // Holds across writes
         model_write(r);
      end
      @(negedge clk3);
      check_state("busy", busy, 1'b0);
      check_state("rd_done", rd_done, 1'b0);
      check_state("wr_done", wr_done, 1'b0);
   endtask

   // Nothing may start or finish
   task automatic expect_idle(input int n);
      repeat (n) begin
         @(negedge clk3);
         req_strobe = 1'b0;
         check_state("busy", busy, 1'b0);
         check_state("rd_done", rd_done, 1'b0);
         check_state("wr_done", wr_done, 1'b0);
      end
   endtask

   initial begin
      cft_bus_pkg::bus_req_t r;
      cft_bus_pkg::bus_req_t x;
      void'($urandom(32'h5a93));
      arst_n     = 1'b0;
      nhalt      = 1'b1;
      req_strobe = 1'b0;
      req        = '0;
      have_rdata = 1'b0;
      last_rdata = '0;
      for (int i = 0; i < `CFT_MEM_DEPTH; i++)
         mem_model[i] = '0;
      for (int i = 0; i < `CFT_IO_DEPTH; i++)
         io_model[i] = '0;
      repeat (RESET_CYCLES) @(posedge clk3);
      @(negedge clk3);
      arst_n = 1'b1;
      check_state("busy", busy, 1'b0);
      check_state("rd_done", rd_done, 1'b0);
      check_state("wr_done", wr_done, 1'b0);

      // Cleared memory, any address
      for (int i = 0; i < N_INIT; i++) begin
         r      = random_req(1'b0);
         r.kind = cft_bus_pkg::KIND_MEM_RD;
         r.addr = ADDR_W'($urandom);
         run_cycle(r, 1'b0, r);
      end

      for (int i = 0; i < N_MEM; i++) begin
         r = random_req(1'b0);
         run_cycle(r, 1'b0, r);
      end

      // I/O traffic, then memory must be intact
      for (int i = 0; i < N_IO; i++) begin
         r = random_req(1'b1);
         run_cycle(r, 1'b0, r);
      end
      for (int i = 0; i < N_RECHECK; i++) begin
         r      = random_req(1'b0);
         r.kind = cft_bus_pkg::KIND_MEM_RD;
         run_cycle(r, 1'b0, r);
      end

      ////////////////////////////////////////
      // Dropped strobes
      ////////////////////////////////////////
      for (int i = 0; i < N_HALT; i++) begin
         r          = random_req(i[0]);
         r.kind     = i[0] ? cft_bus_pkg::KIND_IO_WR : cft_bus_pkg::KIND_MEM_WR;
         nhalt      = 1'b0;
         req        = r;
         req_strobe = 1'b1;
         expect_idle(8);
         nhalt  = 1'b1;
         r.kind = i[0] ? cft_bus_pkg::KIND_IO_RD : cft_bus_pkg::KIND_MEM_RD;
         run_cycle(r, 1'b0, r);   // Target unchanged
      end
      for (int i = 0; i < N_BUSY; i++) begin
         r      = random_req(i[0]);
         r.kind = i[0] ? cft_bus_pkg::KIND_IO_RD : cft_bus_pkg::KIND_MEM_RD;
         x      = r;
         x.kind = i[0] ? cft_bus_pkg::KIND_IO_WR : cft_bus_pkg::KIND_MEM_WR;
         x.wdata = ~model_read(r);   // Would show if stored
         run_cycle(r, 1'b1, x);
         run_cycle(r, 1'b0, r);
      end

      $display("TB PASSED");
      $finish;
   end

endmodule
